// File: vlog.f
verilog/mem_complex_pkg.sv
verilog/mc_fifo.sv
verilog/wormhole_col_router.sv
verilog/mem_link_client.sv
verilog/wormhole_col_merger.sv
verilog/mem_complex.sv
tb/tb_mem_complex.sv

// File: Makefile
TOP := tb_mem_complex

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) > run.log 2>&1 || true
	cat run.log
	@if grep -q "TEST FAILED" run.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" run.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir run.log

// File: tb/tb_mem_complex.sv
`timescale 1ns/1ps

module tb_mem_complex;

  localparam int cols_lp    = mem_complex_pkg::num_cols_lp;
  localparam int timeout_lp = 200;

  logic                                    clk = 1'b0;
  logic                                    rst_n = 1'b0;
  mem_complex_pkg::wh_link_t               cmd_link = '0;
  logic                                    cmd_ready;
  mem_complex_pkg::wh_link_t               resp_link;
  logic                                    resp_ready = 1'b1;
  mem_complex_pkg::mem_msg_t [cols_lp-1:0] dram_cmd;
  logic [cols_lp-1:0]                      dram_cmd_v;
  logic [cols_lp-1:0]                      dram_cmd_yumi = '0;
  mem_complex_pkg::mem_msg_t [cols_lp-1:0] dram_resp = '0;
  logic [cols_lp-1:0]                      dram_resp_v = '0;
  logic [cols_lp-1:0]                      dram_resp_ready;
  mem_complex_pkg::wh_link_t [cols_lp-1:0] coh_req;
  mem_complex_pkg::wh_link_t [cols_lp-1:0] coh_cmd;
  mem_complex_pkg::wh_link_t [cols_lp-1:0] coh_resp;

  logic [127:0]              dram_mem [1024]; // {column, addr[7:0]}
  mem_complex_pkg::mem_msg_t resp_q [cols_lp][$];
  mem_complex_pkg::mem_msg_t cmd_log [$];
  int                        cmd_col_log [$];
  logic [63:0]               resp_flits [$];
  logic [1:0]                yumi_wait [cols_lp] = '{default: '0};
  logic [31:0]               yumi_rng = 32'h6394;
  logic [31:0]               ready_rng = 32'h6394;
  logic                      dram_hold = 1'b0;
  logic                      resp_stall = 1'b0;
  logic                      ready_random = 1'b0;
  int                        n_checks = 0;
  int                        n_errors = 0;

  initial
    begin
      forever
        #2 clk = ~clk;
    end

  mem_complex i_dut
    (.clk_i(clk)
     ,.rst_n_i(rst_n)
     ,.mem_cmd_link_i(cmd_link)
     ,.mem_cmd_link_ready_o(cmd_ready)
     ,.mem_resp_link_o(resp_link)
     ,.mem_resp_link_ready_i(resp_ready)
     ,.dram_cmd_o(dram_cmd)
     ,.dram_cmd_v_o(dram_cmd_v)
     ,.dram_cmd_yumi_i(dram_cmd_yumi)
     ,.dram_resp_i(dram_resp)
     ,.dram_resp_v_i(dram_resp_v)
     ,.dram_resp_ready_o(dram_resp_ready)
     ,.coh_req_link_o(coh_req)
     ,.coh_cmd_link_o(coh_cmd)
     ,.coh_resp_link_o(coh_resp)
     );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [127:0] test_block(input int k);
    logic [31:0] w;
    w = 32'(k) * 32'h9E37_79B1;
    return {w, ~w, w ^ 32'hA5A5_5A5A, 32'hB10C_0000 + 32'(k)};
  endfunction

  function automatic logic [63:0] make_header(input int dest, input int src,
                                              input mem_complex_pkg::mem_op_e op,
                                              input logic [7:0] tag);
    mem_complex_pkg::wh_header_t h;
    h          = '0;
    h.dest_col = 2'(dest);
    h.src_col  = 2'(src);
    h.opcode   = op;
    h.tag      = tag;
    h.len      = (op == mem_complex_pkg::e_mem_wr) ? 4'd3 : 4'd1; // flits after the header
    return h;
  endfunction

  task automatic serve_cmd(input int c, input mem_complex_pkg::mem_msg_t cmd);
    mem_complex_pkg::mem_msg_t resp;
    logic [9:0]                idx;
    idx  = {2'(c), cmd.addr[7:0]};
    resp = cmd;
    if (cmd.opcode == mem_complex_pkg::e_mem_wr)
      dram_mem[idx] = cmd.data;
    else
      resp.data = dram_mem[idx];
    resp_q[c].push_back(resp);
    cmd_log.push_back(cmd);
    cmd_col_log.push_back(c);
  endtask

  // DRAM model, handshakes complete on the rising edge
  always @(posedge clk)
    begin
      for (int c = 0; c < cols_lp; c++)
        begin
          if (dram_cmd_v[c] && dram_cmd_yumi[c])
            serve_cmd(c, dram_cmd[c]);
          if (dram_resp_v[c] && dram_resp_ready[c])
            void'(resp_q[c].pop_front());
        end
    end

  always @(negedge clk)
    begin
      for (int c = 0; c < cols_lp; c++)
        begin
          dram_cmd_yumi[c] = 1'b0;
          if (dram_cmd_v[c] && !dram_hold)
            begin
              if (yumi_wait[c] == 2'd0)
                begin
                  dram_cmd_yumi[c] = 1'b1;
                  yumi_rng         = xorshift32(yumi_rng);
                  yumi_wait[c]     = yumi_rng[1:0]; // delay before the next yumi
                end
              else
                yumi_wait[c] = yumi_wait[c] - 2'd1;
            end
          dram_resp_v[c] = (resp_q[c].size() != 0);
          dram_resp[c]   = dram_resp_v[c] ? resp_q[c][0] : '0;
        end
    end

  always @(negedge clk)
    begin
      if (resp_stall)
        resp_ready = 1'b0;
      else if (ready_random)
        begin
          ready_rng  = xorshift32(ready_rng);
          resp_ready = ready_rng[7];
        end
      else
        resp_ready = 1'b1;
    end

  always @(posedge clk)
    begin
      if (resp_link.v && resp_ready)
        resp_flits.push_back(resp_link.data);
    end

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
    n_checks++;
    if (got !== exp)
      begin
        n_errors++;
        $display("FAIL @%0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      end
  endtask

  task automatic report_timeout(input string what);
    n_errors++;
    $display("timeout at %0t ns while waiting for %s", $time, what);
  endtask

  task automatic offer_flit(input logic [63:0] flit, input int limit, output bit ok);
    int waited;
    @(negedge clk);
    cmd_link.v    = 1'b1;
    cmd_link.data = flit;
    ok            = 1'b0;
    waited        = 0;
    while (!ok && waited < limit)
      begin
        @(posedge clk);
        ok = cmd_ready;
        waited++;
      end
  endtask

  task automatic send_packet(input int dest, input int src, input mem_complex_pkg::mem_op_e op,
                             input logic [7:0] tag, input logic [31:0] addr,
                             input logic [127:0] data);
    logic [63:0] flits [$];
    bit          ok;
    flits.push_back(make_header(dest, src, op, tag));
    flits.push_back(64'(addr));
    if (op == mem_complex_pkg::e_mem_wr)
      begin
        flits.push_back(data[63:0]);
        flits.push_back(data[127:64]);
      end
    foreach (flits[i])
      begin
        offer_flit(flits[i], timeout_lp, ok);
        if (!ok)
          begin
            report_timeout("mem_cmd_link_ready_o");
            break;
          end
      end
    @(negedge clk);
    cmd_link = '0;
  endtask

  task automatic pop_flit(output logic [63:0] flit, output bit ok);
    int waited;
    waited = 0;
    while (resp_flits.size() == 0 && waited < timeout_lp)
      begin
        @(negedge clk);
        waited++;
      end
    ok   = (resp_flits.size() != 0);
    flit = '0;
    if (ok)
      flit = resp_flits.pop_front();
    else
      report_timeout("a flit on mem_resp_link_o");
  endtask

  task automatic recv_packet(output mem_complex_pkg::wh_header_t hdr, output logic [127:0] data);
    logic [63:0] flit;
    bit          ok;
    data = '0;
    pop_flit(flit, ok);
    hdr = flit;
    for (int i = 0; ok && i < int'(hdr.len); i++)
      begin
        pop_flit(flit, ok);
        if (i < 2)
          data[64*i +: 64] = flit;
      end
  endtask

  task automatic check_header(input mem_complex_pkg::wh_header_t hdr, input int dest,
                              input int src, input mem_complex_pkg::mem_op_e op,
                              input logic [7:0] tag);
    check_value(hdr.dest_col, dest, "response dest_col");
    check_value(hdr.src_col, src, "response src_col");
    check_value(hdr.opcode, op, "response opcode");
    check_value(hdr.tag, tag, "response tag");
    check_value(hdr.len, (op == mem_complex_pkg::e_mem_rd) ? 2 : 0, "response len");
    check_value(hdr.pad, 0, "header padding");
  endtask

  task automatic check_cmd(input int col, input int src, input mem_complex_pkg::mem_op_e op,
                           input logic [7:0] tag, input logic [31:0] addr,
                           input logic [127:0] data);
    mem_complex_pkg::mem_msg_t cmd;
    int                        got_col;
    int                        waited;
    waited = 0;
    while (cmd_log.size() == 0 && waited < timeout_lp)
      begin
        @(negedge clk);
        waited++;
      end
    if (cmd_log.size() == 0)
      report_timeout("a command on dram_cmd_o");
    else
      begin
        cmd     = cmd_log.pop_front();
        got_col = cmd_col_log.pop_front();
        check_value(got_col, col, "dram port of command");
        check_value(cmd.opcode, op, "command opcode");
        check_value(cmd.src_col, src, "command src_col");
        check_value(cmd.tag, tag, "command tag");
        check_value(cmd.addr, addr, "command addr");
        if (op == mem_complex_pkg::e_mem_wr)
          check_value(cmd.data, data, "command data");
      end
  endtask

  task automatic test_reset();
    check_value(coh_req == '0, 1, "coh_req_link_o is zero");
    check_value(coh_cmd == '0, 1, "coh_cmd_link_o is zero");
    check_value(coh_resp == '0, 1, "coh_resp_link_o is zero");
    check_value(resp_link.v, 0, "mem_resp_link_o.v after reset");
    check_value(dram_cmd_v, 0, "dram_cmd_v_o after reset");
    check_value(dram_resp_ready, 4'hF, "dram_resp_ready_o after reset");
  endtask

  task automatic test_write_each_col();
    mem_complex_pkg::wh_header_t hdr;
    logic [127:0]                blk;
    logic [31:0]                 addr;
    for (int c = 0; c < cols_lp; c++)
      begin
        addr = 32'h0000_1000 | 32'(c << 4);
        send_packet(c, 3 - c, mem_complex_pkg::e_mem_wr, 8'h10 + 8'(c), addr, test_block(c));
        check_cmd(c, 3 - c, mem_complex_pkg::e_mem_wr, 8'h10 + 8'(c), addr, test_block(c));
        recv_packet(hdr, blk);
        check_header(hdr, 3 - c, c, mem_complex_pkg::e_mem_wr, 8'h10 + 8'(c));
      end
    check_value(cmd_log.size(), 0, "no stray commands");
  endtask

  task automatic test_write_read();
    mem_complex_pkg::wh_header_t hdr;
    logic [127:0]                blk;
    send_packet(2, 1, mem_complex_pkg::e_mem_wr, 8'h20, 32'h0000_2040, test_block(20));
    send_packet(2, 1, mem_complex_pkg::e_mem_rd, 8'h21, 32'h0000_2040, '0);
    recv_packet(hdr, blk);
    check_header(hdr, 1, 2, mem_complex_pkg::e_mem_wr, 8'h20);
    recv_packet(hdr, blk);
    check_header(hdr, 1, 2, mem_complex_pkg::e_mem_rd, 8'h21);
    check_value(blk, test_block(20), "read data");
    cmd_log.delete();
    cmd_col_log.delete();
  endtask

  task automatic test_backpressure();
    mem_complex_pkg::wh_header_t hdr;
    logic [127:0]                blk;
    bit                          ok;
    @(posedge clk);
    dram_hold = 1'b1;
    for (int k = 0; k < 2; k++)
      send_packet(1, 0, mem_complex_pkg::e_mem_wr, 8'h30 + 8'(k), 32'h3000 | 32'(k << 4),
                  test_block(30 + k));
    // both fifo entries full, third packet stalls on its last flit
    blk = test_block(32);
    offer_flit(make_header(1, 0, mem_complex_pkg::e_mem_wr, 8'h32), timeout_lp, ok);
    check_value(ok, 1, "third header accepted");
    offer_flit(64'h3020, timeout_lp, ok);
    check_value(ok, 1, "third addr accepted");
    offer_flit(blk[63:0], timeout_lp, ok);
    check_value(ok, 1, "third data low accepted");
    offer_flit(blk[127:64], 20, ok);
    check_value(ok, 0, "mem_cmd_link_ready_o falls with yumi held");
    check_value(dram_cmd_v, 4'b0010, "dram_cmd_v_o held while yumi withheld");
    check_value(dram_cmd[1].tag, 8'h30, "oldest command at the fifo head");
    @(posedge clk);
    dram_hold = 1'b0;
    offer_flit(blk[127:64], timeout_lp, ok);
    check_value(ok, 1, "stalled flit accepted after release");
    @(negedge clk);
    cmd_link = '0;
    send_packet(1, 0, mem_complex_pkg::e_mem_wr, 8'h33, 32'h3030, test_block(33));
    for (int k = 0; k < 4; k++)
      check_cmd(1, 0, mem_complex_pkg::e_mem_wr, 8'h30 + 8'(k), 32'h3000 | 32'(k << 4),
                test_block(30 + k));
    for (int k = 0; k < 4; k++)
      begin
        recv_packet(hdr, blk);
        check_header(hdr, 0, 1, mem_complex_pkg::e_mem_wr, 8'h30 + 8'(k));
      end
  endtask

  task automatic test_all_columns();
    mem_complex_pkg::wh_header_t hdr;
    logic [127:0]                blk;
    logic [7:0]                  seen;
    logic [2:0]                  slot;
    int                          c;
    int                          waited;
    seen = '0;
    @(posedge clk);
    resp_stall = 1'b1; // let every column queue its responses first
    for (int k = 0; k < cols_lp; k++)
      begin
        send_packet(k, 3 - k, mem_complex_pkg::e_mem_wr, 8'h50 + 8'(k), 32'h5000 | 32'(k << 4),
                    test_block(50 + k));
        send_packet(k, 3 - k, mem_complex_pkg::e_mem_rd, 8'h60 + 8'(k), 32'h5000 | 32'(k << 4),
                    '0);
      end
    waited = 0;
    while (cmd_log.size() < 2 * cols_lp && waited < timeout_lp)
      begin
        @(negedge clk);
        waited++;
      end
    if (cmd_log.size() < 2 * cols_lp)
      report_timeout("all column commands to reach DRAM");
    @(posedge clk);
    resp_stall   = 1'b0;
    ready_random = 1'b1;
    for (int n = 0; n < 2 * cols_lp; n++)
      begin
        recv_packet(hdr, blk);
        c    = int'(hdr.tag[1:0]);
        slot = {hdr.tag[5], hdr.tag[1:0]}; // read tags have bit 5 set
        if ((hdr.tag[7:4] != 4'h5 && hdr.tag[7:4] != 4'h6) || hdr.tag[3:2] != 2'b00)
          check_value(hdr.tag, 8'h50, "known response tag");
        else
          begin
            check_header(hdr, 3 - c, c,
                         hdr.tag[5] ? mem_complex_pkg::e_mem_rd : mem_complex_pkg::e_mem_wr,
                         hdr.tag);
            if (hdr.tag[5])
              check_value(blk, test_block(50 + c), "read data under contention");
            check_value(seen[slot], 0, "tag received once");
            seen[slot] = 1'b1;
          end
      end
    check_value(seen, 8'hFF, "set of received tags");
    @(posedge clk);
    ready_random = 1'b0;
    cmd_log.delete();
    cmd_col_log.delete();
  endtask

  initial
    begin
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      test_reset();
      test_write_each_col();
      test_write_read();
      test_backpressure();
      test_all_columns();
      repeat (4) @(negedge clk);
      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
        $display("TEST OK");
      else
        $display("TEST FAILED");
      $finish;
    end

endmodule

// File: verilog/mem_complex.sv
`timescale 1ns/1ps

module mem_complex
  (input                                                                clk_i
   , input                                                              rst_n_i

   , input  mem_complex_pkg::wh_link_t                                  mem_cmd_link_i
   , output logic                                                       mem_cmd_link_ready_o

   , output mem_complex_pkg::wh_link_t                                  mem_resp_link_o
   , input                                                              mem_resp_link_ready_i

   , output mem_complex_pkg::mem_msg_t [mem_complex_pkg::num_cols_lp-1:0] dram_cmd_o
   , output logic [mem_complex_pkg::num_cols_lp-1:0]                    dram_cmd_v_o
   , input  logic [mem_complex_pkg::num_cols_lp-1:0]                    dram_cmd_yumi_i

   , input  mem_complex_pkg::mem_msg_t [mem_complex_pkg::num_cols_lp-1:0] dram_resp_i
   , input  logic [mem_complex_pkg::num_cols_lp-1:0]                    dram_resp_v_i
   , output logic [mem_complex_pkg::num_cols_lp-1:0]                    dram_resp_ready_o

   , output mem_complex_pkg::wh_link_t [mem_complex_pkg::num_cols_lp-1:0] coh_req_link_o
   , output mem_complex_pkg::wh_link_t [mem_complex_pkg::num_cols_lp-1:0] coh_cmd_link_o
   , output mem_complex_pkg::wh_link_t [mem_complex_pkg::num_cols_lp-1:0] coh_resp_link_o
   );

  mem_complex_pkg::wh_link_t [mem_complex_pkg::num_cols_lp-1:0] col_cmd_link;
  mem_complex_pkg::wh_link_t [mem_complex_pkg::num_cols_lp-1:0] col_resp_link;
  logic [mem_complex_pkg::num_cols_lp-1:0]                      col_cmd_ready;
  logic [mem_complex_pkg::num_cols_lp-1:0]                      col_resp_ready;

  // no coherence traffic in this complex
  assign coh_req_link_o  = '0;
  assign coh_cmd_link_o  = '0;
  assign coh_resp_link_o = '0;

  wormhole_col_router
   i_router
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.link_i(mem_cmd_link_i)
     ,.ready_o(mem_cmd_link_ready_o)
     ,.col_link_o(col_cmd_link)
     ,.col_ready_i(col_cmd_ready)
     );

  for (genvar c = 0; c < mem_complex_pkg::num_cols_lp; c++)
    begin : g_client
      mem_link_client
       #(.col_id_p(mem_complex_pkg::col_id_t'(c)))
       i_client
        (.clk_i(clk_i)
         ,.rst_n_i(rst_n_i)
         ,.cmd_link_i(col_cmd_link[c])
         ,.cmd_ready_o(col_cmd_ready[c])
         ,.resp_link_o(col_resp_link[c])
         ,.resp_ready_i(col_resp_ready[c])
         ,.dram_cmd_o(dram_cmd_o[c])
         ,.dram_cmd_v_o(dram_cmd_v_o[c])
         ,.dram_cmd_yumi_i(dram_cmd_yumi_i[c])
         ,.dram_resp_i(dram_resp_i[c])
         ,.dram_resp_v_i(dram_resp_v_i[c])
         ,.dram_resp_ready_o(dram_resp_ready_o[c])
         );
    end

  wormhole_col_merger
   i_merger
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.col_link_i(col_resp_link)
     ,.col_ready_o(col_resp_ready)
     ,.link_o(mem_resp_link_o)
     ,.ready_i(mem_resp_link_ready_i)
     );

endmodule

// File: verilog/wormhole_col_merger.sv
`timescale 1ns/1ps

module wormhole_col_merger
  (input                                                               clk_i
   , input                                                             rst_n_i

   , input  mem_complex_pkg::wh_link_t [mem_complex_pkg::num_cols_lp-1:0] col_link_i
   , output logic [mem_complex_pkg::num_cols_lp-1:0]                   col_ready_o

   , output mem_complex_pkg::wh_link_t                                 link_o
   , input                                                             ready_i
   );

  mem_complex_pkg::wh_header_t hdr;
  mem_complex_pkg::col_id_t    last_r;
  mem_complex_pkg::col_id_t    grant_r;
  mem_complex_pkg::col_id_t    grant;
  mem_complex_pkg::col_id_t    pick;
  mem_complex_pkg::col_id_t    idx;
  mem_complex_pkg::len_t       count_r;
  logic                        locked_r;
  logic                        found;
  logic                        accept;

  // round robin, search starts after the last winner
  always_comb
    begin
      found = 1'b0;
      pick  = last_r;
      idx   = last_r;
      for (int i = 1; i <= mem_complex_pkg::num_cols_lp; i++)
        begin
          idx = last_r + mem_complex_pkg::col_id_t'(i); // wraps, num_cols is a power of two
          if (!found && col_link_i[idx].v)
            begin
              found = 1'b1;
              pick  = idx;
            end
        end
    end

  assign grant       = locked_r ? grant_r : pick;
  assign link_o.v    = col_link_i[grant].v;
  assign link_o.data = col_link_i[grant].data;
  assign hdr         = col_link_i[grant].data;
  assign accept      = link_o.v & ready_i;

  always_comb
    begin
      for (int c = 0; c < mem_complex_pkg::num_cols_lp; c++)
        col_ready_o[c] = ready_i & (grant == mem_complex_pkg::col_id_t'(c));
    end

  always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        begin
          locked_r <= 1'b0;
          grant_r  <= '0;
          count_r  <= '0;
          last_r   <= mem_complex_pkg::col_id_t'(mem_complex_pkg::num_cols_lp - 1);
        end
      else if (accept)
        begin
          if (!locked_r)
            begin
              grant_r <= grant;
              count_r <= hdr.len;
              if (hdr.len != '0)
                locked_r <= 1'b1;
              else
                last_r <= grant; // single flit packet
            end
          else
            begin
              count_r <= count_r - 1'b1;
              if (count_r == mem_complex_pkg::len_t'(1))
                begin
                  locked_r <= 1'b0;
                  last_r   <= grant_r;
                end
            end
        end
    end

endmodule

// File: verilog/mem_link_client.sv
`timescale 1ns/1ps

module mem_link_client
 #(parameter mem_complex_pkg::col_id_t col_id_p = '0)
  (input                                 clk_i
   , input                               rst_n_i

   , input  mem_complex_pkg::wh_link_t   cmd_link_i
   , output logic                        cmd_ready_o

   , output mem_complex_pkg::wh_link_t   resp_link_o
   , input                               resp_ready_i

   , output mem_complex_pkg::mem_msg_t   dram_cmd_o
   , output logic                        dram_cmd_v_o
   , input                               dram_cmd_yumi_i

   , input  mem_complex_pkg::mem_msg_t   dram_resp_i
   , input                               dram_resp_v_i
   , output logic                        dram_resp_ready_o
   );

  localparam int fw_lp = mem_complex_pkg::flit_width_lp;
  localparam int dw_lp = mem_complex_pkg::data_width_lp;

  typedef enum logic [1:0] {e_des_hdr, e_des_addr, e_des_lo, e_des_hi} des_state_e;
  typedef enum logic [1:0] {e_ser_hdr, e_ser_lo, e_ser_hi} ser_state_e;

  des_state_e                  des_state_r;
  ser_state_e                  ser_state_r;
  mem_complex_pkg::wh_header_t cmd_hdr;
  mem_complex_pkg::wh_header_t resp_hdr;
  mem_complex_pkg::mem_msg_t   cmd_msg_r;
  mem_complex_pkg::mem_msg_t   cmd_msg;
  mem_complex_pkg::mem_msg_t   resp_msg;
  logic                        cmd_enq_v;
  logic                        cmd_fifo_ready;
  logic                        cmd_accept;
  logic                        resp_fifo_v;
  logic                        resp_last;
  logic                        resp_accept;
  logic                        resp_yumi;

  assign cmd_hdr    = cmd_link_i.data;
  assign cmd_accept = cmd_link_i.v & cmd_ready_o;

  // the last flit completes the message and enqueues it in the same cycle
  always_comb
    begin
      cmd_msg     = cmd_msg_r;
      cmd_enq_v   = 1'b0;
      cmd_ready_o = 1'b1;
      case (des_state_r)
        e_des_addr:
          begin
            cmd_msg.addr = cmd_link_i.data[mem_complex_pkg::addr_width_lp-1:0];
            if (cmd_msg_r.opcode == mem_complex_pkg::e_mem_rd)
              begin
                cmd_enq_v   = cmd_link_i.v;
                cmd_ready_o = cmd_fifo_ready;
              end
          end
        e_des_hi:
          begin
            cmd_msg.data = {cmd_link_i.data, cmd_msg_r.data[fw_lp-1:0]};
            cmd_enq_v    = cmd_link_i.v;
            cmd_ready_o  = cmd_fifo_ready;
          end
        default: ;
      endcase
    end

  always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        des_state_r <= e_des_hdr;
      else if (cmd_accept)
        case (des_state_r)
          e_des_hdr:  des_state_r <= e_des_addr;
          e_des_addr: des_state_r <= (cmd_msg_r.opcode == mem_complex_pkg::e_mem_wr)
                                     ? e_des_lo : e_des_hdr;
          e_des_lo:   des_state_r <= e_des_hi;
          default:    des_state_r <= e_des_hdr;
        endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (cmd_accept)
        case (des_state_r)
          e_des_hdr:
            begin
              cmd_msg_r.opcode  <= cmd_hdr.opcode;
              cmd_msg_r.src_col <= cmd_hdr.src_col;
              cmd_msg_r.tag     <= cmd_hdr.tag;
            end
          e_des_addr: cmd_msg_r.addr <= cmd_msg.addr;
          e_des_lo:   cmd_msg_r.data[fw_lp-1:0] <= cmd_link_i.data;
          default: ;
        endcase
    end

  mc_fifo
   #(.data_t(mem_complex_pkg::mem_msg_t))
   i_cmd_fifo
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.data_i(cmd_msg)
     ,.v_i(cmd_enq_v)
     ,.ready_o(cmd_fifo_ready)
     ,.data_o(dram_cmd_o)
     ,.v_o(dram_cmd_v_o)
     ,.yumi_i(dram_cmd_yumi_i)
     );

  mc_fifo
   #(.data_t(mem_complex_pkg::mem_msg_t))
   i_resp_fifo
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.data_i(dram_resp_i)
     ,.v_i(dram_resp_v_i)
     ,.ready_o(dram_resp_ready_o)
     ,.data_o(resp_msg)
     ,.v_o(resp_fifo_v)
     ,.yumi_i(resp_yumi)
     );

  // response goes back to the column that sent the command
  always_comb
    begin
      resp_hdr          = '0;
      resp_hdr.dest_col = resp_msg.src_col;
      resp_hdr.src_col  = col_id_p;
      resp_hdr.opcode   = resp_msg.opcode;
      resp_hdr.tag      = resp_msg.tag;
      resp_hdr.len      = (resp_msg.opcode == mem_complex_pkg::e_mem_rd)
                          ? mem_complex_pkg::rd_resp_len_lp
                          : mem_complex_pkg::wr_resp_len_lp;
      resp_link_o.v = resp_fifo_v; // head stays in the fifo until the tail leaves
      case (ser_state_r)
        e_ser_lo:
          begin
            resp_link_o.data = resp_msg.data[fw_lp-1:0];
            resp_last        = 1'b0;
          end
        e_ser_hi:
          begin
            resp_link_o.data = resp_msg.data[dw_lp-1:fw_lp];
            resp_last        = 1'b1;
          end
        default:
          begin
            resp_link_o.data = resp_hdr;
            resp_last        = (resp_msg.opcode == mem_complex_pkg::e_mem_wr);
          end
      endcase
    end

  assign resp_accept = resp_link_o.v & resp_ready_i;
  assign resp_yumi   = resp_accept & resp_last;

  always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        ser_state_r <= e_ser_hdr;
      else if (resp_accept)
        case (ser_state_r)
          e_ser_hdr: ser_state_r <= resp_last ? e_ser_hdr : e_ser_lo;
          e_ser_lo:  ser_state_r <= e_ser_hi;
          default:   ser_state_r <= e_ser_hdr;
        endcase
    end

endmodule

// File: verilog/wormhole_col_router.sv
`timescale 1ns/1ps

module wormhole_col_router
  (input                                                               clk_i
   , input                                                             rst_n_i

   , input  mem_complex_pkg::wh_link_t                                 link_i
   , output logic                                                      ready_o

   , output mem_complex_pkg::wh_link_t [mem_complex_pkg::num_cols_lp-1:0] col_link_o
   , input  logic [mem_complex_pkg::num_cols_lp-1:0]                   col_ready_i
   );

  mem_complex_pkg::wh_header_t hdr;
  mem_complex_pkg::col_id_t    route;
  mem_complex_pkg::col_id_t    route_r;
  mem_complex_pkg::len_t       count_r;
  logic                        locked_r;
  logic                        accept;

  assign hdr    = link_i.data;
  assign route  = locked_r ? route_r : hdr.dest_col; // idle flit is always a header
  assign accept = link_i.v & ready_o;

  assign ready_o = col_ready_i[route];

  always_comb
    begin
      for (int c = 0; c < mem_complex_pkg::num_cols_lp; c++)
        begin
          col_link_o[c].v    = link_i.v & (route == mem_complex_pkg::col_id_t'(c));
          col_link_o[c].data = link_i.data;
        end
    end

  always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        begin
          locked_r <= 1'b0;
          route_r  <= '0;
          count_r  <= '0;
        end
      else if (accept)
        begin
          if (!locked_r)
            begin
              // header with no body leaves the router idle
              locked_r <= (hdr.len != '0);
              route_r  <= hdr.dest_col;
              count_r  <= hdr.len;
            end
          else
            begin
              count_r <= count_r - 1'b1;
              if (count_r == mem_complex_pkg::len_t'(1))
                locked_r <= 1'b0; // tail flit
            end
        end
    end

endmodule

// File: verilog/mc_fifo.sv
`timescale 1ns/1ps

module mc_fifo
 #(parameter type data_t = logic)
  (input                 clk_i
   , input               rst_n_i

   , input  data_t       data_i
   , input               v_i
   , output logic        ready_o

   , output data_t       data_o
   , output logic        v_o
   , input               yumi_i
   );

  data_t      mem_r [2];
  logic       rd_ptr_r;
  logic       wr_ptr_r;
  logic [1:0] count_r;
  logic       enq;

  assign ready_o = (count_r != 2'd2);
  assign v_o     = (count_r != 2'd0);
  assign data_o  = mem_r[rd_ptr_r];
  assign enq     = v_i & ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        begin
          rd_ptr_r <= 1'b0;
          wr_ptr_r <= 1'b0;
          count_r  <= 2'd0;
        end
      else
        begin
          if (enq)
            wr_ptr_r <= ~wr_ptr_r;
          if (yumi_i)
            rd_ptr_r <= ~rd_ptr_r;
          count_r <= count_r + {1'b0, enq} - {1'b0, yumi_i}; // yumi only while v_o
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (enq)
        mem_r[wr_ptr_r] <= data_i;
    end

endmodule

// File: verilog/mem_complex_pkg.sv
package mem_complex_pkg;

  localparam int num_cols_lp      = 4;
  localparam int col_id_width_lp  = 2;
  localparam int flit_width_lp    = 64;
  localparam int addr_width_lp    = 32;
  localparam int data_width_lp    = 2 * flit_width_lp; // one block is two flits
  localparam int len_width_lp     = 4;
  localparam int tag_width_lp     = 8;
  localparam int op_width_lp      = 2;
  localparam int hdr_pad_width_lp = flit_width_lp - 2 * col_id_width_lp - len_width_lp
                                    - op_width_lp - tag_width_lp;

  typedef logic [col_id_width_lp-1:0] col_id_t;
  typedef logic [len_width_lp-1:0]    len_t;
  typedef logic [tag_width_lp-1:0]    tag_t;

  // number of flits after the header
  localparam len_t wr_cmd_len_lp  = len_t'(3);  // addr, data lo, data hi
  localparam len_t rd_cmd_len_lp  = len_t'(1);  // addr
  localparam len_t rd_resp_len_lp = len_t'(2);  // data lo, data hi
  localparam len_t wr_resp_len_lp = len_t'(0);  // header only

  typedef enum logic [op_width_lp-1:0]
  {
    e_mem_rd = 2'b00
    , e_mem_wr = 2'b01
  } mem_op_e;

  // first flit of every packet
  typedef struct packed
  {
    logic [hdr_pad_width_lp-1:0] pad;
    tag_t                        tag;
    mem_op_e                     opcode;
    len_t                        len;
    col_id_t                     src_col;
    col_id_t                     dest_col;
  } wh_header_t;

  typedef struct packed
  {
    mem_op_e                  opcode;
    col_id_t                  src_col;
    tag_t                     tag;
    logic [addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0] data;
  } mem_msg_t;

  // ready runs the other way, outside the struct
  typedef struct packed
  {
    logic                     v;
    logic [flit_width_lp-1:0] data;
  } wh_link_t;

endpackage
